// ==== mem_settings.svh ====
// Bus, address and counter width macros, included by every RTL file and by the testbench
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ==============================
// Memory bus geometry
// ==============================

// Bytes carried by one bus beat, which is also the size of one line
`define MEM_BUS_BYTES 8

// Width of the virtual and physical byte addresses
`define MEM_ADDR_BITS 32

// Log2 of the page size; an access may not run over into the next page
`define MEM_PAGE_BITS 12

// ==============================
// Timeout and retry counters
// ==============================

// Width of the timeout counter and of the timeout length setting
`define MEM_TO_BITS 8

// Width of the retry counter and of the retry limit setting
`define MEM_RETRY_BITS 3

`endif

// ==== mem_bus_pkg.sv ====
// Memory bus side types (access size, fault code, slot state) for the slot RTL and testbench
`default_nettype none

package mem_bus_pkg;

	// Access width, encoded as log2 of the byte count
	typedef enum logic [1:0] {
		SZ_BYTE  = 2'd0,
		SZ_HALF  = 2'd1,
		SZ_WORD  = 2'd2,
		SZ_DWORD = 2'd3
	} mem_size_e;

	// Fault reported with a result
	// FLT_ALN covers page crossing and misalignment with unaligned support off
	// FLT_BUS means the bus never answered after all retries
	typedef enum logic [1:0] {
		FLT_NONE = 2'd0,
		FLT_ALN  = 2'd1,
		FLT_BUS  = 2'd2
	} mem_fault_e;

	// Slot state
	// The two active states are the only ones that hold the bus cycle up
	typedef enum logic [2:0] {
		SLOT_AVAIL     = 3'd0,
		SLOT_ACTIVE    = 3'd1,
		SLOT_DELAY     = 3'd2,
		SLOT_HI_ACTIVE = 3'd3,
		SLOT_RETRY     = 3'd4,
		SLOT_DONE      = 3'd5
	} slot_state_e;

endpackage

`default_nettype wire

// ==== lsq_pkg.sv ====
// Pipeline side types (result tag, operation kind) for the slot RTL and testbench
`default_nettype none

package lsq_pkg;

	// Tag that identifies the result to the pipeline
	// Five bits cover a 32 entry window of outstanding operations
	typedef logic [4:0] rob_tag_t;

	// Direction of the memory operation
	// A load returns data and a store returns value zero
	typedef enum logic {
		OP_LOAD  = 1'b0,
		OP_STORE = 1'b1
	} mem_op_e;

endpackage

`default_nettype wire

// ==== mem_slot_cfg.sv ====
// Configuration registers for the memory slot, written by strobe and read by the slot as levels
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module mem_slot_cfg (
	input  wire                        clk_i,
	input  wire                        rst_i,
	input  wire                        cfg_we_i,
	input  wire [1:0]                  cfg_addr_i,
	input  wire [7:0]                  cfg_wdata_i,
	output logic                       unaligned_en_o,
	output logic [`MEM_TO_BITS-1:0]    to_len_o,
	output logic [`MEM_RETRY_BITS-1:0] retry_max_o
);

	// ==============================
	// Register map
	// ==============================

	// Address 0 bit 0 enables unaligned accesses
	// Address 1 sets the cycles a beat may wait before it is retried
	// Address 2 sets the number of retries before a bus error
	// Address 3 is not decoded
	localparam logic [1:0] ADDR_CTRL  = 2'd0;
	localparam logic [1:0] ADDR_TOLEN = 2'd1;
	localparam logic [1:0] ADDR_RETRY = 2'd2;

	// Values after reset
	localparam logic [`MEM_TO_BITS-1:0]    TO_LEN_RST    = `MEM_TO_BITS'(32);
	localparam logic [`MEM_RETRY_BITS-1:0] RETRY_MAX_RST = `MEM_RETRY_BITS'(2);

	// ==============================
	// Write decode
	// ==============================

	// A write lands at the clock edge that samples the strobe
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			unaligned_en_o <= 1'b1;
			to_len_o       <= TO_LEN_RST;
			retry_max_o    <= RETRY_MAX_RST;
		end else if (cfg_we_i) begin
			case (cfg_addr_i)
				ADDR_CTRL: begin
					unaligned_en_o <= cfg_wdata_i[0];
				end
				ADDR_TOLEN: begin
					to_len_o <= cfg_wdata_i[`MEM_TO_BITS-1:0];
				end
				ADDR_RETRY: begin
					// Upper data bits beyond the counter width are dropped
					retry_max_o <= cfg_wdata_i[`MEM_RETRY_BITS-1:0];
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== mem_load_format.sv ====
// Combinational load formatter used by the slot to merge, align and extend bus read data
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module mem_load_format
	import mem_bus_pkg::*;
(
	input  wire [8*`MEM_BUS_BYTES-1:0]        lo_dat_i,
	input  wire [8*`MEM_BUS_BYTES-1:0]        hi_dat_i,
	input  wire [$clog2(`MEM_BUS_BYTES)-1:0]  offset_i,
	input  wire mem_size_e                    size_i,
	input  wire                               signed_i,
	output logic [8*`MEM_BUS_BYTES-1:0]       val_o
);

	localparam int DW = 8 * `MEM_BUS_BYTES;

	// Both beats side by side, the high line above the low one
	logic [2*DW-1:0] pair;
	// Pair moved down so the first byte of the access sits in lane 0
	logic [2*DW-1:0] pair_sh;
	// Lowest beat of the aligned pair
	logic [DW-1:0]   aligned;
	logic            sign_bit;

	// ==============================
	// Merge and align
	// ==============================

	// An unsplit access arrives with the same beat on both inputs
	// The bytes above the access are then masked off below
	assign pair    = {hi_dat_i, lo_dat_i};
	assign pair_sh = pair >> {offset_i, 3'b000};
	assign aligned = pair_sh[DW-1:0];

	// ==============================
	// Mask and extend
	// ==============================

	always_comb begin
		case (size_i)
			SZ_BYTE: begin
				sign_bit = signed_i & aligned[7];
				val_o    = {{(DW-8){sign_bit}}, aligned[7:0]};
			end
			SZ_HALF: begin
				sign_bit = signed_i & aligned[15];
				val_o    = {{(DW-16){sign_bit}}, aligned[15:0]};
			end
			SZ_WORD: begin
				sign_bit = signed_i & aligned[31];
				val_o    = {{(DW-32){sign_bit}}, aligned[31:0]};
			end
			default: begin
				// A full double word has nothing to extend
				sign_bit = 1'b0;
				val_o    = aligned;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== mem_slot_work.sv ====
// Memory slot FSM, instanced by the top level; runs one request on the bus and reports its result
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module mem_slot_work
	import mem_bus_pkg::*;
	import lsq_pkg::*;
(
	input  wire                         clk_i,
	input  wire                         rst_i,
	input  wire                         req_i,
	input  wire mem_op_e                req_op_i,
	input  wire mem_size_e              req_size_i,
	input  wire                         req_signed_i,
	input  wire [`MEM_ADDR_BITS-1:0]    req_vaddr_i,
	input  wire [`MEM_ADDR_BITS-1:0]    req_paddr_i,
	input  wire [63:0]                  req_data_i,
	input  wire rob_tag_t               req_tag_i,
	input  wire                         flush_i,
	input  wire                         unaligned_en_i,
	input  wire [`MEM_TO_BITS-1:0]      to_len_i,
	input  wire [`MEM_RETRY_BITS-1:0]   retry_max_i,
	input  wire                         bus_ack_i,
	input  wire [63:0]                  bus_dat_i,
	output logic                        busy_o,
	output logic                        bus_cyc_o,
	output logic                        bus_we_o,
	output logic [`MEM_ADDR_BITS-1:0]   bus_adr_o,
	output logic [7:0]                  bus_sel_o,
	output logic [63:0]                 bus_dat_o,
	output logic                        res_v_o,
	output rob_tag_t                    res_tag_o,
	output logic [63:0]                 res_val_o,
	output mem_fault_e                  res_exc_o
);

	localparam int NB = `MEM_BUS_BYTES;
	localparam int DW = 8 * NB;
	localparam int OB = $clog2(NB);
	localparam int AW = `MEM_ADDR_BITS;
	localparam int PB = `MEM_PAGE_BITS;

	// Control state
	slot_state_e                state_q;
	logic                       hi_q;
	logic [`MEM_TO_BITS-1:0]    to_cnt_q;
	logic [`MEM_RETRY_BITS-1:0] retry_q;

	// Request payload, held for the whole access
	mem_op_e             op_q;
	mem_size_e           size_q;
	logic                signed_q;
	logic [OB-1:0]       offset_q;
	logic                split_q;
	rob_tag_t            tag_q;
	mem_fault_e          exc_q;
	logic [AW-1:0]       lo_adr_q, hi_adr_q;
	logic [NB-1:0]       lo_sel_q, hi_sel_q;
	logic [DW-1:0]       lo_dat_q, hi_dat_q;
	logic [DW-1:0]       lo_rd_q;
	logic [DW-1:0]       res_val_q;

	// Request decode
	logic [OB-1:0]       req_off;
	logic [NB-1:0]       size_mask;
	logic [2*NB-1:0]     sel_wide;
	logic [2*DW-1:0]     dat_wide;
	logic [AW-OB-1:0]    next_vline;
	logic                req_split, req_page_cross, req_misalign, req_fault;
	logic                accept, timeout, ack_last, give_up;
	logic [DW-1:0]       fmt_lo, fmt_val;

	// ==============================
	// Selects, split and faults
	// ==============================

	assign req_off = req_vaddr_i[OB-1:0];

	always_comb begin
		case (req_size_i)
			SZ_BYTE: begin
				size_mask    = NB'(8'h01);
				req_misalign = 1'b0;
			end
			SZ_HALF: begin
				size_mask    = NB'(8'h03);
				req_misalign = req_off[0];
			end
			SZ_WORD: begin
				size_mask    = NB'(8'h0f);
				req_misalign = |req_off[1:0];
			end
			default: begin
				size_mask    = NB'(8'hff);
				req_misalign = |req_off;
			end
		endcase
	end

	// Lanes spilling into the upper half belong to the next line
	assign sel_wide  = {{NB{1'b0}}, size_mask} << req_off;
	assign dat_wide  = {{DW{1'b0}}, req_data_i} << {req_off, 3'b000};
	assign req_split = |sel_wide[2*NB-1:NB];

	// The next line is in another page when the line number carries into the page bits
	assign next_vline     = req_vaddr_i[AW-1:OB] + 1'b1;
	assign req_page_cross = req_split && (next_vline[AW-OB-1:PB-OB] != req_vaddr_i[AW-1:PB]);
	assign req_fault      = req_page_cross || (req_misalign && !unaligned_en_i);

	// A flush in the same cycle wins over a new request
	assign accept = (state_q == SLOT_AVAIL) && req_i && !flush_i;

	// Timeout fires in the to_len-th cycle of a beat without acknowledge
	assign timeout  = (to_cnt_q == to_len_i - 1'b1);
	assign ack_last = bus_cyc_o && bus_ack_i && !((state_q == SLOT_ACTIVE) && split_q);
	assign give_up  = bus_cyc_o && !bus_ack_i && timeout && (retry_q == retry_max_i);

	// ==============================
	// State machine
	// ==============================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q  <= SLOT_AVAIL;
			hi_q     <= 1'b0;
			to_cnt_q <= '0;
			retry_q  <= '0;
		end else if (flush_i) begin
			// A late acknowledge finds the slot idle and is dropped
			state_q <= SLOT_AVAIL;
			hi_q    <= 1'b0;
		end else begin
			// Counter only runs while the bus cycle is up
			to_cnt_q <= bus_cyc_o ? to_cnt_q + 1'b1 : '0;
			case (state_q)
				SLOT_AVAIL: begin
					if (accept) begin
						hi_q    <= 1'b0;
						retry_q <= '0;
						state_q <= req_fault ? SLOT_DONE : SLOT_ACTIVE;
					end
				end
				SLOT_ACTIVE, SLOT_HI_ACTIVE: begin
					if (bus_ack_i) begin
						state_q <= ack_last ? SLOT_DONE : SLOT_DELAY;
					end else if (give_up) begin
						state_q <= SLOT_DONE;
					end else if (timeout) begin
						retry_q <= retry_q + 1'b1;
						state_q <= SLOT_RETRY;
					end
				end
				SLOT_DELAY: begin
					hi_q    <= 1'b1;
					state_q <= SLOT_HI_ACTIVE;
				end
				SLOT_RETRY: begin
					// Reissue whichever beat timed out
					state_q <= hi_q ? SLOT_HI_ACTIVE : SLOT_ACTIVE;
				end
				default: begin
					state_q <= SLOT_AVAIL;
				end
			endcase
		end
	end

	// ==============================
	// Payload capture
	// ==============================

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_q      <= req_op_i;
			size_q    <= req_size_i;
			signed_q  <= req_signed_i;
			offset_q  <= req_off;
			split_q   <= req_split;
			tag_q     <= req_tag_i;
			exc_q     <= req_fault ? FLT_ALN : FLT_NONE;
			lo_adr_q  <= {req_paddr_i[AW-1:OB], {OB{1'b0}}};
			hi_adr_q  <= {req_paddr_i[AW-1:OB] + 1'b1, {OB{1'b0}}};
			lo_sel_q  <= sel_wide[NB-1:0];
			hi_sel_q  <= sel_wide[2*NB-1:NB];
			lo_dat_q  <= dat_wide[DW-1:0];
			hi_dat_q  <= dat_wide[2*DW-1:DW];
			res_val_q <= '0;
		end
		// Low beat of a split load waits here for the merge
		if ((state_q == SLOT_ACTIVE) && bus_ack_i) begin
			lo_rd_q <= bus_dat_i;
		end
		if (ack_last && (op_q == OP_LOAD)) begin
			res_val_q <= fmt_val;
		end
		if (give_up) begin
			exc_q <= FLT_BUS;
		end
	end

	// Unsplit loads feed the live beat to both formatter inputs
	assign fmt_lo = split_q ? lo_rd_q : bus_dat_i;

	mem_load_format u_fmt (
		.lo_dat_i (fmt_lo),
		.hi_dat_i (bus_dat_i),
		.offset_i (offset_q),
		.size_i   (size_q),
		.signed_i (signed_q),
		.val_o    (fmt_val)
	);

	// ==============================
	// Outputs
	// ==============================

	assign busy_o    = (state_q != SLOT_AVAIL);
	assign bus_cyc_o = (state_q == SLOT_ACTIVE) || (state_q == SLOT_HI_ACTIVE);
	assign bus_we_o  = bus_cyc_o && (op_q == OP_STORE);
	assign bus_adr_o = hi_q ? hi_adr_q : lo_adr_q;
	assign bus_sel_o = hi_q ? hi_sel_q : lo_sel_q;
	assign bus_dat_o = hi_q ? hi_dat_q : lo_dat_q;
	assign res_v_o   = (state_q == SLOT_DONE);
	assign res_tag_o = tag_q;
	assign res_val_o = res_val_q;
	assign res_exc_o = exc_q;

	// Requester must wait for busy to fall
	a_no_req_busy: assert property (@(posedge clk_i) disable iff (rst_i) req_i |-> !busy_o);

	// Every beat put on the bus carries at least one byte lane
	a_sel_on_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
		bus_cyc_o |-> (bus_sel_o != '0));

	// One pulse per request
	a_res_pulse: assert property (@(posedge clk_i) disable iff (rst_i) res_v_o |=> !res_v_o);

endmodule

`default_nettype wire

// ==== mem_slot_top.sv ====
// Top level of the memory slot, joining the configuration registers to the slot FSM
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module mem_slot_top
	import mem_bus_pkg::*;
	import lsq_pkg::*;
(
	input  wire                        clk_i,
	input  wire                        rst_i,
	// Configuration write port
	input  wire                        cfg_we_i,
	input  wire [1:0]                  cfg_addr_i,
	input  wire [7:0]                  cfg_wdata_i,
	// Request from the pipeline
	input  wire                        req_i,
	input  wire mem_op_e               req_op_i,
	input  wire mem_size_e             req_size_i,
	input  wire                        req_signed_i,
	input  wire [`MEM_ADDR_BITS-1:0]   req_vaddr_i,
	input  wire [`MEM_ADDR_BITS-1:0]   req_paddr_i,
	input  wire [63:0]                 req_data_i,
	input  wire rob_tag_t              req_tag_i,
	input  wire                        flush_i,
	// Memory bus
	input  wire                        bus_ack_i,
	input  wire [63:0]                 bus_dat_i,
	output logic                       busy_o,
	output logic                       bus_cyc_o,
	output logic                       bus_we_o,
	output logic [`MEM_ADDR_BITS-1:0]  bus_adr_o,
	output logic [7:0]                 bus_sel_o,
	output logic [63:0]                bus_dat_o,
	// Result to the pipeline
	output logic                       res_v_o,
	output rob_tag_t                   res_tag_o,
	output logic [63:0]                res_val_o,
	output mem_fault_e                 res_exc_o
);

	// Settings held as levels by the register block
	logic                       unaligned_en;
	logic [`MEM_TO_BITS-1:0]    to_len;
	logic [`MEM_RETRY_BITS-1:0] retry_max;

	mem_slot_cfg u_cfg (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.cfg_we_i       (cfg_we_i),
		.cfg_addr_i     (cfg_addr_i),
		.cfg_wdata_i    (cfg_wdata_i),
		.unaligned_en_o (unaligned_en),
		.to_len_o       (to_len),
		.retry_max_o    (retry_max)
	);

	mem_slot_work u_work (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.req_i          (req_i),
		.req_op_i       (req_op_i),
		.req_size_i     (req_size_i),
		.req_signed_i   (req_signed_i),
		.req_vaddr_i    (req_vaddr_i),
		.req_paddr_i    (req_paddr_i),
		.req_data_i     (req_data_i),
		.req_tag_i      (req_tag_i),
		.flush_i        (flush_i),
		.unaligned_en_i (unaligned_en),
		.to_len_i       (to_len),
		.retry_max_i    (retry_max),
		.bus_ack_i      (bus_ack_i),
		.bus_dat_i      (bus_dat_i),
		.busy_o         (busy_o),
		.bus_cyc_o      (bus_cyc_o),
		.bus_we_o       (bus_we_o),
		.bus_adr_o      (bus_adr_o),
		.bus_sel_o      (bus_sel_o),
		.bus_dat_o      (bus_dat_o),
		.res_v_o        (res_v_o),
		.res_tag_o      (res_tag_o),
		.res_val_o      (res_val_o),
		.res_exc_o      (res_exc_o)
	);

endmodule

`default_nettype wire

// ==== tb_mem_slot.sv ====
// Self-checking testbench for the memory slot top level; compile it with the file list and run it
`timescale 1ns/1ns
`default_nettype none
`include "mem_settings.svh"

module tb_mem_slot
	import mem_bus_pkg::*, lsq_pkg::*;
;

	// Worst case per request is (retry_max+1)*(to_len+2) cycles
	// About 30 requests at the reset settings need some 3100 cycles and the rest is margin
	localparam int MAX_CYCLES = 4000;

	logic clk_i, rst_i, cfg_we_i, req_i, req_signed_i, flush_i, bus_ack_i;
	logic [1:0] cfg_addr_i;
	logic [7:0] cfg_wdata_i;
	mem_op_e req_op_i;
	mem_size_e req_size_i;
	logic [31:0] req_vaddr_i, req_paddr_i;
	logic [63:0] req_data_i, bus_dat_i;
	rob_tag_t req_tag_i;
	logic busy_o, bus_cyc_o, bus_we_o, res_v_o;
	logic [31:0] bus_adr_o;
	logic [7:0] bus_sel_o;
	logic [63:0] bus_dat_o, res_val_o;
	rob_tag_t res_tag_o;
	mem_fault_e res_exc_o;

	// Memory model lines and its control
	logic [63:0] mem [64];
	logic mem_dead, cyc_seen;
	logic [1:0] ack_wait;
	int beat_cnt;
	logic [31:0] beat_adr [4];
	logic [7:0] beat_sel [4];

	// Expected result of the request in flight
	rob_tag_t exp_tag, next_tag;
	logic [63:0] exp_val;
	mem_fault_e exp_exc;
	logic exp_live, unal_en;
	logic [15:0] stim_lfsr, ack_lfsr;
	int cycle_cnt;

	mem_slot_top DUT (.*);

	initial clk_i = 1'b0;
	always #2 clk_i = ~clk_i;

	// ==============================
	// Helpers
	// ==============================

	// Steps a 16-bit Fibonacci LFSR once per bit and collects the new bits
	function automatic logic [31:0] take_bits(inout logic [15:0] st, input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = st[15] ^ st[13] ^ st[12] ^ st[10];
			st = {st[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// Reads the bytes of a load from the model array and extends them
	function automatic logic [63:0] model_load(input logic [31:0] addr, input int nb,
		input logic sgn);
		logic [63:0] v;
		logic [31:0] a;
		v = '0;
		for (int i = 0; i < nb; i++) begin
			a = addr + 32'(i);
			v[8*i +: 8] = mem[a[8:3]][8*a[2:0] +: 8];
		end
		if (sgn && nb < 8 && v[8*nb-1])
			v = v | ~((64'd1 << (8*nb)) - 64'd1);
		return v;
	endfunction

	task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		$display("FAILED %s expected %h got %h", name, exp, got);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_plain(input string what);
		$display("Error: %s", what);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic step();
		@(posedge clk_i);
		#1;
	endtask

	task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data);
		cfg_we_i = 1'b1;
		cfg_addr_i = addr;
		cfg_wdata_i = data;
		step();
		cfg_we_i = 1'b0;
		if (addr == 2'd0)
			unal_en = data[0];
	endtask

	// ==============================
	// Memory model and beat monitor
	// ==============================

	always @(posedge clk_i) begin
		#1;
		bus_ack_i = 1'b0;
		if (bus_cyc_o && !cyc_seen) begin
			if (beat_cnt < 4) begin
				beat_adr[beat_cnt] = bus_adr_o;
				beat_sel[beat_cnt] = bus_sel_o;
			end
			beat_cnt++;
		end
		cyc_seen = bus_cyc_o;
		// A fresh delay of 0 to 3 cycles is drawn while the bus is idle
		if (!bus_cyc_o) begin
			ack_wait = 2'(take_bits(ack_lfsr, 2));
		end else if (!mem_dead) begin
			if (ack_wait == 2'd0) begin
				bus_ack_i = 1'b1;
				if (bus_we_o) begin
					for (int b = 0; b < 8; b++)
						if (bus_sel_o[b])
							mem[bus_adr_o[8:3]][8*b +: 8] = bus_dat_o[8*b +: 8];
				end
				bus_dat_i = mem[bus_adr_o[8:3]];
				// Blocks a second acknowledge before the cycle falls
				ack_wait = 2'd3;
			end else begin
				ack_wait = ack_wait - 2'd1;
			end
		end
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Error: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("test failed");
			$fatal(1);
		end
	end

	// ==============================
	// Result checks
	// ==============================

	a_res_live: assert property (@(posedge clk_i) disable iff (rst_i) res_v_o |-> exp_live)
		else report_plain("a result pulse came with no live request");
	a_res_tag: assert property (@(posedge clk_i) disable iff (rst_i)
		res_v_o |-> res_tag_o == exp_tag)
		else report_value("res_tag_o", 64'(exp_tag), 64'($sampled(res_tag_o)));
	a_res_val: assert property (@(posedge clk_i) disable iff (rst_i)
		res_v_o |-> res_val_o == exp_val)
		else report_value("res_val_o", exp_val, $sampled(res_val_o));
	a_res_exc: assert property (@(posedge clk_i) disable iff (rst_i)
		res_v_o |-> res_exc_o == exp_exc)
		else report_value("res_exc_o", 64'(exp_exc), 64'($sampled(res_exc_o)));

	// Issues one request, waits for its result and checks the bus beats it made
	task automatic run_req(input mem_op_e op, input logic [1:0] size, input logic sgn,
		input logic [31:0] addr, input logic [63:0] data);
		int nb;
		int n;
		logic split, pcross, fault;
		logic [15:0] sel_w;
		nb = 1 << size;
		split = (32'(addr[2:0]) + 32'(nb)) > 32'd8;
		pcross = split && ((((addr | 32'h7) + 32'd1) >> 12) != (addr >> 12));
		fault = pcross || ((addr % 32'(nb)) != 0 && !unal_en);
		sel_w = 16'((17'd1 << nb) - 17'd1) << addr[2:0];
		exp_tag = next_tag;
		next_tag = next_tag + 5'd1;
		exp_exc = fault ? FLT_ALN : (mem_dead ? FLT_BUS : FLT_NONE);
		exp_val = (exp_exc == FLT_NONE && op == OP_LOAD) ? model_load(addr, nb, sgn) : 64'd0;
		exp_live = 1'b1;
		beat_cnt = 0;
		req_i = 1'b1;
		req_op_i = op;
		req_size_i = mem_size_e'(size);
		req_signed_i = sgn;
		req_vaddr_i = addr;
		req_paddr_i = addr;
		req_data_i = data;
		req_tag_i = exp_tag;
		step();
		req_i = 1'b0;
		n = 1;
		while (!res_v_o) begin
			step();
			n++;
		end
		if (fault) begin
			assert (n == 1 && beat_cnt == 0)
				else report_plain("an alignment fault started a bus cycle or came late");
		end else if (!mem_dead) begin
			assert (beat_cnt == (split ? 2 : 1))
				else report_value("beat count", split ? 64'd2 : 64'd1, 64'(beat_cnt));
			assert (beat_adr[0] == {addr[31:3], 3'b000})
				else report_value("bus_adr_o", 64'({addr[31:3], 3'b000}), 64'(beat_adr[0]));
			assert (beat_sel[0] == sel_w[7:0])
				else report_value("bus_sel_o", 64'(sel_w[7:0]), 64'(beat_sel[0]));
			if (split) begin
				assert (beat_adr[1] == {addr[31:3] + 29'd1, 3'b000})
					else report_value("bus_adr_o", 64'({addr[31:3] + 29'd1, 3'b000}),
						64'(beat_adr[1]));
				assert (beat_sel[1] == sel_w[15:8])
					else report_value("bus_sel_o", 64'(sel_w[15:8]), 64'(beat_sel[1]));
			end
		end
		step();
		// Any further pulse before the next request is a stray result
		exp_live = 1'b0;
	endtask

	// Stores random data, loads it back and compares with the written bytes
	task automatic store_load(input logic [1:0] size, input logic [31:0] addr);
		logic [63:0] data;
		logic [63:0] mask;
		data = {take_bits(stim_lfsr, 32), take_bits(stim_lfsr, 32)};
		mask = (size == 2'd3) ? '1 : ((64'd1 << (8 << size)) - 64'd1);
		run_req(OP_STORE, size, 1'b0, addr, data);
		run_req(OP_LOAD, size, 1'b0, addr, 64'd0);
		assert (res_val_o == (data & mask))
			else report_value("res_val_o", data & mask, res_val_o);
	endtask

	// ==============================
	// Stimulus
	// ==============================

	initial begin
		logic [31:0] addr;
		rst_i = 1'b1;
		{cfg_we_i, req_i, req_signed_i, flush_i, bus_ack_i} = '0;
		cfg_addr_i = '0;
		cfg_wdata_i = '0;
		req_op_i = OP_LOAD;
		req_size_i = SZ_BYTE;
		{req_vaddr_i, req_paddr_i, req_data_i, bus_dat_i} = '0;
		req_tag_i = '0;
		{mem_dead, cyc_seen, exp_live, next_tag, exp_tag} = '0;
		exp_val = '0;
		exp_exc = FLT_NONE;
		unal_en = 1'b1;
		stim_lfsr = 16'd5229;
		ack_lfsr = 16'd5229;
		ack_wait = '0;
		beat_cnt = 0;
		cycle_cnt = 0;
		// Fill pattern mixes all address bits of each byte
		for (int a = 0; a < 512; a++)
			mem[a >> 3][8*(a % 8) +: 8] = 8'(a * 7 + (a >> 3) * 13 + 8'h3c);
		repeat (5) @(posedge clk_i);
		#1;
		rst_i = 1'b0;
		step();

		// Aligned accesses of every size and sign
		for (int s = 0; s < 4; s++) begin
			for (int g = 0; g < 2; g++) begin
				addr = take_bits(stim_lfsr, 9) & ~(32'(1 << s) - 32'd1);
				run_req(OP_LOAD, 2'(s), 1'(g), addr, 64'd0);
			end
			addr = take_bits(stim_lfsr, 9) & ~(32'(1 << s) - 32'd1);
			store_load(2'(s), addr);
		end

		// Line straddling accesses inside one page
		run_req(OP_LOAD, 2'd2, 1'b1, 32'h005, 64'd0);
		run_req(OP_LOAD, 2'd1, 1'b1, 32'h017, 64'd0);
		run_req(OP_LOAD, 2'd3, 1'b0, 32'h043, 64'd0);
		store_load(2'd3, 32'h1a3);

		// Page crossing, then misaligned with unaligned support off
		run_req(OP_LOAD, 2'd2, 1'b0, 32'hffe, 64'd0);
		write_cfg(2'd0, 8'h00);
		run_req(OP_LOAD, 2'd1, 1'b0, 32'h011, 64'd0);
		run_req(OP_STORE, 2'd2, 1'b0, 32'h022, 64'h1234);
		run_req(OP_LOAD, 2'd2, 1'b1, 32'h024, 64'd0);
		write_cfg(2'd0, 8'h01);

		// Dead memory ends in a bus error after one retry
		write_cfg(2'd1, 8'd8);
		write_cfg(2'd2, 8'd1);
		mem_dead = 1'b1;
		run_req(OP_LOAD, 2'd3, 1'b0, 32'h080, 64'd0);
		assert (beat_cnt == 2) else report_value("beat count", 64'd2, 64'(beat_cnt));
		mem_dead = 1'b0;
		write_cfg(2'd1, 8'd32);
		write_cfg(2'd2, 8'd2);

		// Flush during a bus cycle, then a normal request with a fresh tag
		mem_dead = 1'b1;
		exp_live = 1'b1;
		req_i = 1'b1;
		req_op_i = OP_LOAD;
		req_size_i = SZ_WORD;
		req_vaddr_i = 32'h0c0;
		req_paddr_i = 32'h0c0;
		req_tag_i = next_tag;
		next_tag = next_tag + 5'd1;
		step();
		req_i = 1'b0;
		while (!bus_cyc_o)
			step();
		flush_i = 1'b1;
		exp_live = 1'b0;
		step();
		flush_i = 1'b0;
		assert (!bus_cyc_o && !busy_o) else report_plain("the flush did not free the slot");
		repeat (12) step();
		mem_dead = 1'b0;
		run_req(OP_LOAD, 2'd2, 1'b1, 32'h0c4, 64'd0);

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
mem_bus_pkg.sv
lsq_pkg.sv
mem_slot_cfg.sv
mem_load_format.sv
mem_slot_work.sv
mem_slot_top.sv
tb_mem_slot.sv

// ==== run.sh ====
#!/bin/sh
# Builds the memory slot testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_mem_slot -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vtb_mem_slot 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
echo "Pass message not found"
exit 1
